// File: vlog.f
src/lr_pkg.sv
src/alu_execute.sv
src/reg_writeback.sv
src/fetch_decode.sv
src/lr_core.sv
sim/tb_lr_core.sv

// File: run.sh
#!/bin/sh
# build and run the lr_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_lr_core

./obj_dir/Vtb_lr_core > sim.log
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1

// File: sim/lr_core_cases.txt
// id | 16 program bytes from reset_pc | store adr hi lo | store data | flags znhc
// one case per line, stored values are from the last write of the program
01 3E 5A 47 2E 80 70 76 00 00 00 00 00 00 00 00 00 00 80 5A 00
02 2E 81 36 C3 56 2E 82 72 76 00 00 00 00 00 00 00 00 82 C3 00
03 3E 8F 06 81 80 2E 80 77 76 00 00 00 00 00 00 00 00 80 10 03
04 37 3E 0E CE 01 2E 80 77 76 00 00 00 00 00 00 00 00 80 10 02
05 2E 80 36 10 3E 10 96 2E 81 77 76 00 00 00 00 00 00 81 00 0C
06 37 3E 20 DE 0F 2E 80 77 76 00 00 00 00 00 00 00 00 80 10 06
07 06 20 3E 10 90 2E 80 77 76 00 00 00 00 00 00 00 00 80 F0 05
08 37 3E F0 E6 0F 2E 80 77 76 00 00 00 00 00 00 00 00 80 00 0A
09 2E 80 36 3C 3E 0F 37 AE 2E 81 77 76 00 00 00 00 00 81 33 00
0A 06 12 3E 41 37 B0 2E 80 77 76 00 00 00 00 00 00 00 80 53 00
0B 3E 42 FE 42 2E 80 77 76 00 00 00 00 00 00 00 00 00 80 42 0C
0C 06 50 3E 42 B8 2E 80 77 76 00 00 00 00 00 00 00 00 80 42 05
0D 37 3E FF 3C 2E 80 77 76 00 00 00 00 00 00 00 00 00 80 00 0B
0E 37 06 01 05 2E 80 70 76 00 00 00 00 00 00 00 00 00 80 00 0D
0F 37 0E 10 0D 2E 80 71 76 00 00 00 00 00 00 00 00 00 80 0F 07
10 37 3E 35 2F 2E 80 77 76 00 00 00 00 00 00 00 00 00 80 CA 07
11 3E 00 B7 37 3F 3F 2E 80 77 76 00 00 00 00 00 00 00 80 00 09
12 00 3E 77 C2 0B 00 2E 80 77 76 00 2E 90 77 76 00 00 90 77 00
13 00 3E 77 CA 0B 00 2E 80 77 76 00 2E 90 77 76 00 00 80 77 00
14 37 3E 77 DA 0B 00 2E 80 77 76 00 2E 90 77 76 00 00 90 77 01
15 37 3E 77 D2 0B 00 2E 80 77 76 00 2E 90 77 76 00 00 80 77 01
16 00 3E 77 C3 0B 00 2E 80 77 76 00 2E 90 77 76 00 00 90 77 00
17 B7 3E 77 28 06 2E 80 77 76 00 00 2E 90 77 76 00 00 90 77 08
18 B7 3E 77 20 06 2E 80 77 76 00 00 2E 90 77 76 00 00 80 77 08
19 00 3E 77 30 06 2E 80 77 76 00 00 2E 90 77 76 00 00 90 77 00
1A 00 3E 77 38 06 2E 80 77 76 00 00 2E 90 77 76 00 00 80 77 00
1B 00 3E 77 18 06 2E 80 77 76 00 00 2E 90 77 76 00 00 90 77 00
1C 06 03 05 20 FD 2E 80 70 76 00 00 00 00 00 00 00 00 80 00 0C

// File: sim/tb_lr_core.sv
module tb_lr_core import lr_pkg::*; ();

	localparam addr_t start_pc     = 16'h0000;
	localparam int    case_bytes   = 21;    // id, 16 program bytes, adr hi, adr lo, data, flags.
	localparam int    max_cases    = 64;
	localparam int    read_timeout = 20;    // clocks from reset to the first fetch.
	localparam int    halt_timeout = 400;
	localparam int    halt_hold    = 40;    // clocks that read must stay low after halt.

	logic   clk;
	logic   reset;
	byte_t  din;
	addr_t  adr;
	byte_t  dout;
	logic   read;
	logic   write;
	logic   halted;
	addr_t  pc;
	flags_t flags;

	byte_t  mem [256];                        // program and data space.
	byte_t  cases [max_cases * case_bytes];
	int     errors;
	int     checks;
	int     case_id;
	int     stores;                           // stores seen in the running case.
	addr_t  store_adr;
	byte_t  store_data;
	logic   write_q;

	lr_core #(
		.reset_pc(start_pc)
	) lr_core_i (
		.clk(clk),
		.reset(reset),
		.din(din),
		.adr(adr),
		.dout(dout),
		.read(read),
		.write(write),
		.halted(halted),
		.pc(pc),
		.flags(flags)
	);

	always #4 clk = ~clk;   // 8 unit period.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model, updated just after the edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		#1;
		if (!reset && write) begin
			mem[adr[7:0]] = dout;
			if (!write_q) begin          // write is two clocks wide, log it once.
				stores     = stores + 1;
				store_adr  = adr;
				store_data = dout;
			end
		end
		write_q = write;
		din = mem[adr[7:0]];             // data is ready the clock after the address.
	end

	// compare one value, log a mismatch.
	task automatic check(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks = checks + 1;
		if (got !== expected) begin
			errors = errors + 1;
			$display("mismatch %s: got %h expected %h in case %0d", name, got, expected,
				case_id);
		end
	endtask

	// clear the memory and copy one program in at the start address.
	task automatic load_program(input int base);
		for (int i = 0; i < 256; i++)
			mem[i] = 8'h00;
		for (int i = 0; i < 16; i++)
			mem[8'(start_pc[7:0] + 8'(i))] = cases[base + 1 + i];
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one program from reset to halt.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_case(input int base);
		int     n;
		addr_t  exp_adr;
		byte_t  exp_data;
		flags_t exp_flags;
		case_id   = int'(cases[base]);
		exp_adr   = {cases[base + 17], cases[base + 18]};
		exp_data  = cases[base + 19];
		exp_flags = flags_t'(cases[base + 20][3:0]);
		reset = 1'b1;
		load_program(base);
		stores = 0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		check("halted", 16'(halted), 16'h0000);   // reset leaves halt.
		check("pc", pc, start_pc);                 // pc starts at the reset address.

		// first fetch goes to the reset address.
		n = 0;
		while (!read && n < read_timeout) begin
			@(posedge clk);
			#1 n = n + 1;
		end
		if (!read) begin
			errors = errors + 1;
			$display("case %0d: no bus read after reset", case_id);
		end else
			check("adr", adr, start_pc);

		n = 0;
		while (!halted && n < halt_timeout) begin
			@(posedge clk);
			#1 n = n + 1;
		end
		if (!halted) begin
			errors = errors + 1;
			$display("case %0d: program did not halt within %0d clocks", case_id, halt_timeout);
		end else begin
			repeat (halt_hold) begin   // no fetch while halted.
				@(posedge clk);
				#1 check("read", 16'(read), 16'h0000);
			end
			if (stores == 0) begin
				errors = errors + 1;
				$display("case %0d: program made no store", case_id);
			end else begin
				check("adr", store_adr, exp_adr);          // last store shows the path.
				check("dout", 16'(store_data), 16'(exp_data));
			end
			check("flags", 16'(flags), 16'(exp_flags));
		end
	endtask

	initial begin
		int k;
		clk     = 1'b0;
		reset   = 1'b1;
		din     = 8'h00;
		errors  = 0;
		checks  = 0;
		case_id = 0;
		stores  = 0;
		write_q = 1'b0;
		for (k = 0; k < max_cases * case_bytes; k++)
			cases[k] = 8'h00;                       // id 00 marks the end of the list.
		$readmemh("sim/lr_core_cases.txt", cases);
		k = 0;
		while (k < max_cases && cases[k * case_bytes] != 8'h00) begin
			run_case(k * case_bytes);
			k = k + 1;
		end
		if (k == 0) begin
			errors = errors + 1;
			$display("no test cases were loaded");
		end
		$display("%0d cases, %0d checks, %0d errors", k, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: src/lr_core.sv
module lr_core import lr_pkg::*; #(
	parameter addr_t reset_pc = 16'h0000
) (
	input  logic   clk,
	input  logic   reset,
	input  byte_t  din,
	output addr_t  adr,
	output byte_t  dout,
	output logic   read,
	output logic   write,
	output logic   halted,
	output addr_t  pc,
	output flags_t flags
);

	regs_t regs;          // committed register state.
	uop_t  uop;
	byte_t imm;
	wb_t   wb;
	logic  take_branch;
	logic  commit;

	// bus, sequencer and decode.
	fetch_decode #(
		.reset_pc(reset_pc)
	) fetch_decode_i (
		.clk(clk),
		.reset(reset),
		.din(din),
		.regs(regs),
		.take_branch(take_branch),
		.adr(adr),
		.dout(dout),
		.read(read),
		.write(write),
		.pc(pc),
		.halted(halted),
		.uop(uop),
		.imm(imm),
		.commit(commit)
	);

	alu_execute alu_execute_i (
		.uop(uop),
		.imm(imm),
		.regs(regs),
		.wb(wb),
		.take_branch(take_branch)
	);

	reg_writeback reg_writeback_i (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.wb(wb),
		.regs(regs)
	);

	assign flags = regs.f;

endmodule

// File: src/fetch_decode.sv
module fetch_decode import lr_pkg::*; #(
	parameter addr_t reset_pc = 16'h0000
) (
	input  logic  clk,
	input  logic  reset,
	input  byte_t din,
	input  regs_t regs,
	input  logic  take_branch,
	output addr_t adr,
	output byte_t dout,
	output logic  read,
	output logic  write,
	output addr_t pc,
	output logic  halted,
	output uop_t  uop,
	output byte_t imm,
	output logic  commit
);

	seq_state_t state_q, state_d;
	logic [1:0] cycle_q;      // clock within the machine cycle.
	byte_t      din_q;
	byte_t      op_q;
	byte_t      imm_hi_q;     // high byte of a jp target.
	logic       fetching;
	logic       reading;
	logic       uses_hl_src;
	logic       from_imm;
	logic       from_mem;
	logic       to_mem;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// opcode decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		uop = '{kind: uop_nop, alu_op: alu_op_t'(op_q[5:3]), src: reg_sel_t'(op_q[2:0]),
			dst: reg_sel_t'(op_q[5:3]), dec: op_q[0], fop: fop_cpl, cond: cond_always};
		casez (op_q)
			op_halt: ;                                 // sequencer stops after it.
			8'b01??_????: uop.kind = uop_load;         // ld r,r' and the (hl) forms.
			8'b10??_????: begin
				uop.kind = uop_alu;
				uop.dst  = sel_a;
			end
			8'b11??_?110: begin                        // alu a,d8.
				uop.kind = uop_alu;
				uop.src  = sel_ind_hl;
				uop.dst  = sel_a;
			end
			8'b00??_?110: begin                        // ld r,d8.
				uop.kind = uop_load;
				uop.src  = sel_ind_hl;
			end
			8'b00??_?10?: if (op_q[5:3] != 3'd6) begin // inc/dec (hl) is not decoded.
				uop.kind = uop_incdec;
				uop.src  = reg_sel_t'(op_q[5:3]);
			end
			op_cpl: begin
				uop.kind = uop_flag_op;
				uop.dst  = sel_a;
			end
			op_scf: begin
				uop.kind = uop_flag_op;
				uop.fop  = fop_scf;
			end
			op_ccf: begin
				uop.kind = uop_flag_op;
				uop.fop  = fop_ccf;
			end
			op_jp, op_jr: uop.kind = uop_branch;
			8'b110?_?010, 8'b001?_?000: begin          // jp cc and jr cc.
				uop.kind = uop_branch;
				uop.cond = cond_t'({1'b0, op_q[4:3]} + 3'd1);
			end
			default: ;                                 // anything else runs as nop.
		endcase
	end

	// code 6 means d8 for one half of each group and (hl) for the other.
	assign uses_hl_src = (uop.kind == uop_load || uop.kind == uop_alu) && uop.src == sel_ind_hl;
	assign from_mem    = uses_hl_src && (op_q[6] ^ (uop.kind == uop_alu));
	assign from_imm    = (uses_hl_src && !from_mem) || uop.kind == uop_branch;
	assign to_mem      = uop.kind == uop_load && uop.dst == sel_ind_hl;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer, decided in cycle 3.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d = st_ifetch;
		case (state_q)
			st_ifetch: begin
				if (from_imm)
					state_d = st_imml_fetch;
				else if (from_mem)
					state_d = st_indirect_fetch;
				else if (to_mem)
					state_d = st_indirect_store;
			end
			st_imml_fetch: begin
				if (uop.kind == uop_branch && op_q[7])
					state_d = st_immh_fetch;   // jp needs the high byte.
				else if (uop.kind == uop_branch && take_branch)
					state_d = st_jump;
				else if (to_mem)
					state_d = st_indirect_store;
			end
			st_immh_fetch:
				if (take_branch)
					state_d = st_jump;
			default: ;                          // read, store and jump end the instruction.
		endcase
	end

	assign fetching = state_q inside {st_ifetch, st_imml_fetch, st_immh_fetch};
	assign reading  = fetching || state_q == st_indirect_fetch;
	assign commit   = cycle_q == 2'd3 && state_d == st_ifetch;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_ifetch;
			cycle_q <= 2'd0;
			pc      <= reset_pc;
			op_q    <= op_nop;
			read    <= 1'b0;
			write   <= 1'b0;
			halted  <= 1'b0;
		end else begin
			read  <= reading && !cycle_q[1] && !halted;   // high in cycles 1 and 2.
			write <= (cycle_q == 2'd3 && state_d == st_indirect_store) ||
				(state_q == st_indirect_store && cycle_q == 2'd0);
			if (!halted)
				cycle_q <= cycle_q + 2'd1;
			if (cycle_q == 2'd3)
				state_q <= state_d;
			if (fetching && cycle_q == 2'd1)
				pc <= pc + 16'd1;
			if (state_q == st_ifetch && cycle_q == 2'd2)
				op_q <= din_q;
			if (state_q == st_jump && cycle_q == 2'd3)
				pc <= op_q[7] ? {imm_hi_q, imm} : pc + {{8{imm[7]}}, imm};
			if (commit && op_q == op_halt)
				halted <= 1'b1;   // only reset leaves halt.
		end
	end

	// bus address, store data and byte latches.
	always_ff @(posedge clk) begin
		din_q <= din;
		if (fetching && cycle_q == 2'd0 && !halted) begin
			adr <= pc;
		end else if (cycle_q == 2'd3 &&
			(state_d == st_indirect_fetch || state_d == st_indirect_store)) begin
			adr  <= {regs.h, regs.l};
			dout <= sel_reg(regs, uop.src, imm);   // d8 or source register.
		end
		if (cycle_q == 2'd2) begin
			case (state_q)
				st_imml_fetch:     imm      <= din_q;
				st_immh_fetch:     imm_hi_q <= din_q;
				st_indirect_fetch: imm      <= din_q;   // (hl) operand.
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(read && write));
	// commit lands on the idle bus clock that closes a machine cycle.
	assert property (@(posedge clk) disable iff (reset)
		commit |-> (!read && !write) ##1 cycle_q == 2'd0);

endmodule

// File: src/reg_writeback.sv
module reg_writeback import lr_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  commit,
	input  wb_t   wb,
	output regs_t regs
);

	byte_t  a_q;
	byte_t  b_q;
	byte_t  c_q;
	byte_t  d_q;
	byte_t  e_q;
	byte_t  h_q;
	byte_t  l_q;
	flags_t f_q;   // znhc.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register file.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= 8'h00;
			b_q <= 8'h00;
			c_q <= 8'h00;
			d_q <= 8'h00;
			e_q <= 8'h00;
			h_q <= 8'h00;
			l_q <= 8'h00;
			f_q <= '0;
		end else if (commit) begin
			if (wb.we) begin
				case (wb.dst)
					sel_b:   b_q <= wb.value;
					sel_c:   c_q <= wb.value;
					sel_d:   d_q <= wb.value;
					sel_e:   e_q <= wb.value;
					sel_h:   h_q <= wb.value;
					sel_l:   l_q <= wb.value;
					sel_a:   a_q <= wb.value;
					default: ;   // (hl) lives in memory.
				endcase
			end
			// masked flag update, unmasked bits hold.
			f_q <= (wb.fmask & wb.flags) | (~wb.fmask & f_q);
		end
	end

	assign regs = '{
		a: a_q,
		b: b_q,
		c: c_q,
		d: d_q,
		e: e_q,
		h: h_q,
		l: l_q,
		f: f_q
	};

	// a committed register write never carries the (hl) code.
	assert property (@(posedge clk) disable iff (reset)
		commit && wb.we |-> wb.dst != sel_ind_hl);

endmodule

// File: src/alu_execute.sv
module alu_execute import lr_pkg::*; (
	input  uop_t  uop,
	input  byte_t imm,
	input  regs_t regs,
	output wb_t   wb,
	output logic  take_branch
);

	byte_t      opd;
	logic       cin;
	logic [8:0] sum;         // bit 8 is carry or borrow.
	logic [4:0] half;        // bit 4 is carry or borrow out of bit 3.
	byte_t      alu_res;
	flags_t     alu_flags;
	byte_t      idc_res;
	flags_t     idc_flags;

	assign opd = sel_reg(regs, uop.src, imm);
	assign cin = (uop.alu_op == alu_adc || uop.alu_op == alu_sbc) && regs.f.c;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 8-bit alu.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sum       = 9'h000;
		half      = 5'h00;
		alu_flags = '0;
		case (uop.alu_op)
			alu_add, alu_adc: begin
				sum         = {1'b0, regs.a} + {1'b0, opd} + {8'h00, cin};
				half        = {1'b0, regs.a[3:0]} + {1'b0, opd[3:0]} + {4'h0, cin};
				alu_flags.h = half[4];
				alu_flags.c = sum[8];
			end
			alu_sub, alu_sbc, alu_cp: begin
				sum         = {1'b0, regs.a} - {1'b0, opd} - {8'h00, cin};
				half        = {1'b0, regs.a[3:0]} - {1'b0, opd[3:0]} - {4'h0, cin};
				alu_flags.n = 1'b1;
				alu_flags.h = half[4];
				alu_flags.c = sum[8];
			end
			alu_and: begin
				sum         = {1'b0, regs.a & opd};
				alu_flags.h = 1'b1;
			end
			alu_xor: sum = {1'b0, regs.a ^ opd};
			default: sum = {1'b0, regs.a | opd};
		endcase
		alu_res     = sum[7:0];
		alu_flags.z = alu_res == 8'h00;
	end

	// inc/dec keeps the carry.
	always_comb begin
		idc_res     = uop.dec ? opd - 8'd1 : opd + 8'd1;
		idc_flags.z = idc_res == 8'h00;
		idc_flags.n = uop.dec;
		idc_flags.h = uop.dec ? opd[3:0] == 4'h0 : opd[3:0] == 4'hf;
		idc_flags.c = regs.f.c;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		wb = '{we: 1'b0, dst: uop.dst, value: opd, fmask: '0, flags: '0};
		case (uop.kind)
			uop_load: wb.we = uop.dst != sel_ind_hl;   // a store goes out on the bus.
			uop_alu: begin
				wb.we    = uop.alu_op != alu_cp;      // cp only sets flags.
				wb.value = alu_res;
				wb.fmask = 4'hf;
				wb.flags = alu_flags;
			end
			uop_incdec: begin
				wb.we    = 1'b1;
				wb.value = idc_res;
				wb.fmask = '{z: 1'b1, n: 1'b1, h: 1'b1, c: 1'b0};
				wb.flags = idc_flags;
			end
			uop_flag_op: begin
				wb.we    = uop.fop == fop_cpl;
				wb.value = ~regs.a;
				wb.fmask = '{z: 1'b0, n: 1'b1, h: 1'b1, c: uop.fop != fop_cpl};
				wb.flags = '{z: 1'b0, n: uop.fop == fop_cpl, h: uop.fop == fop_cpl,
					c: uop.fop == fop_scf || !regs.f.c};
			end
			default: ;                                  // nop and branch write nothing.
		endcase
	end

	// condition against the committed flags.
	always_comb begin
		case (uop.cond)
			cond_always: take_branch = 1'b1;
			cond_nz:     take_branch = !regs.f.z;
			cond_z:      take_branch = regs.f.z;
			cond_nc:     take_branch = !regs.f.c;
			cond_c:      take_branch = regs.f.c;
			default:     take_branch = 1'b0;
		endcase
	end

	always_comb begin
		if (uop.kind == uop_alu && wb.we)
			assert (uop.dst != sel_ind_hl);
	end

endmodule

// File: src/lr_pkg.sv
package lr_pkg;

	typedef logic [7:0]  byte_t;   // data word on the bus and in registers.
	typedef logic [15:0] addr_t;   // bus address.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// opcode fields.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// register codes in opcode field order, code 6 is the (hl) operand.
	typedef enum logic [2:0] {
		sel_b, sel_c, sel_d, sel_e, sel_h, sel_l, sel_ind_hl, sel_a
	} reg_sel_t;

	// alu group, opcode bits 5:3.
	typedef enum logic [2:0] {
		alu_add, alu_adc, alu_sub, alu_sbc, alu_and, alu_xor, alu_or, alu_cp
	} alu_op_t;

	typedef enum logic [1:0] {
		fop_cpl, fop_scf, fop_ccf
	} flag_op_t;

	typedef enum logic [2:0] {
		cond_always, cond_nz, cond_z, cond_nc, cond_c
	} cond_t;

	typedef enum logic [2:0] {
		uop_nop, uop_load, uop_alu, uop_incdec, uop_flag_op, uop_branch
	} uop_kind_t;

	// one machine cycle per state.
	typedef enum logic [5:0] {
		st_ifetch         = 6'b000001,
		st_imml_fetch     = 6'b000010,
		st_immh_fetch     = 6'b000100,
		st_indirect_fetch = 6'b001000,
		st_indirect_store = 6'b010000,
		st_jump           = 6'b100000
	} seq_state_t;

	// single opcodes picked out by the decoder.
	localparam byte_t op_nop  = 8'h00;
	localparam byte_t op_halt = 8'h76;
	localparam byte_t op_cpl  = 8'h2f;
	localparam byte_t op_scf  = 8'h37;
	localparam byte_t op_ccf  = 8'h3f;
	localparam byte_t op_jp   = 8'hc3;
	localparam byte_t op_jr   = 8'h18;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage payloads.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic z;   // zero.
		logic n;   // subtract.
		logic h;   // half carry.
		logic c;   // carry.
	} flags_t;

	typedef struct packed {
		uop_kind_t kind;
		alu_op_t   alu_op;
		reg_sel_t  src;
		reg_sel_t  dst;
		logic      dec;     // inc/dec picks decrement.
		flag_op_t  fop;
		cond_t     cond;
	} uop_t;

	typedef struct packed {
		byte_t  a;
		byte_t  b;
		byte_t  c;
		byte_t  d;
		byte_t  e;
		byte_t  h;
		byte_t  l;
		flags_t f;
	} regs_t;

	typedef struct packed {
		logic     we;       // register write.
		reg_sel_t dst;
		byte_t    value;
		flags_t   fmask;    // flag bits to update.
		flags_t   flags;
	} wb_t;

	// operand read, code 6 returns the immediate / memory latch.
	function automatic byte_t sel_reg(regs_t regs, reg_sel_t sel, byte_t imm);
		case (sel)
			sel_b:      sel_reg = regs.b;
			sel_c:      sel_reg = regs.c;
			sel_d:      sel_reg = regs.d;
			sel_e:      sel_reg = regs.e;
			sel_h:      sel_reg = regs.h;
			sel_l:      sel_reg = regs.l;
			sel_ind_hl: sel_reg = imm;
			default:    sel_reg = regs.a;
		endcase
	endfunction

endpackage
